/* common/xform_pkg.sv */
package xform_pkg;

    // fixed-point format
    localparam int FRAC_BITS = 8;               // q8.8
    localparam int FIX_W     = 16;              // coordinate width
    localparam int PROD_W    = 2 * FIX_W;       // full product width

    typedef logic signed [FIX_W-1:0]  fix16_t;  // one coordinate
    typedef logic signed [PROD_W-1:0] prod_t;   // untruncated product or sum

    typedef fix16_t [2:0] vec3_t;               // [0] x, [1] y, [2] z
    typedef fix16_t [3:0] quat_t;               // [0] real, [1] i, [2] j, [3] k

    // pipeline depths, all in advancing cycles
    localparam int QMUL_LAT  = 2;               // products, then sums
    localparam int LANE_LAT  = 1;
    localparam int ROT_LAT   = 2 * QMUL_LAT;    // q*v, then (q*v)*q'
    localparam int XFORM_LAT = LANE_LAT + ROT_LAT + LANE_LAT;

    typedef enum logic {
        LANE_MUL,                               // scale
        LANE_ADD                                // translate
    } lane_op_e;

    // hamilton product term signs, [component][term], 1 = subtract
    // term t of component r is a[t] * b[r ^ t]
    localparam logic [3:0][3:0] QMUL_NEG = {
        4'b0100,                                // k: + + - +
        4'b0010,                                // j: + - + +
        4'b1000,                                // i: + + + -
        4'b1110                                 // real: + - - -
    };

    // full signed product, no rounding
    function automatic prod_t fix_prod(input fix16_t a, input fix16_t b);
        return prod_t'(a) * prod_t'(b);         // sign-extended operands
    endfunction

    // back to q8.8, floor shift then drop high bits
    function automatic fix16_t fix_trunc(input prod_t p);
        return fix16_t'(p >>> FRAC_BITS);
    endfunction

endpackage

/* hdl/pipe_delay.sv */
`timescale 1ns/100ps

module pipe_delay #(
    parameter type payload_t = logic,           // side data carried along
    parameter int  DEPTH     = 1                // cycles of delay, at least 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,                        // global advance
    input  payload_t d,
    output payload_t q
);

    payload_t stage [DEPTH];                    // [0] nearest the input

    // data only, moves with the pipeline
    always_ff @(posedge clk) begin
        if (en) begin                           // frozen with the pipeline
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];         // shift toward q
            end
        end
    end

    assign q = stage[DEPTH-1];                  // oldest entry

endmodule

/* hdl/vec_lane_op.sv */
`timescale 1ns/100ps

module vec_lane_op import xform_pkg::*; #(
    parameter lane_op_e OP = LANE_MUL           // mul for scale, add for translate
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,                           // global advance
    input  logic  valid_in,
    input  vec3_t a,                            // point
    input  vec3_t b,                            // scale or offset
    output logic  valid_out,
    output vec3_t y
);

    vec3_t y_d;                                 // next lane results

    // three independent lanes
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (OP == LANE_MUL) begin
                y_d[i] = fix_trunc(fix_prod(a[i], b[i]));   // q8.8 product
            end else begin
                y_d[i] = a[i] + b[i];           // wraps on overflow
            end
        end
    end

    // single register stage, data has no reset
    always_ff @(posedge clk) begin
        if (en) begin
            y <= y_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (en) begin
            valid_out <= valid_in;              // bubbles move too
        end
    end

endmodule

/* hdl/xform_top.sv */
`timescale 1ns/100ps

// scale, rotate, translate as one stalling pipeline
module xform_top import xform_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    // input side
    input  logic  in_valid,
    output logic  in_ready,
    input  vec3_t point,
    input  vec3_t scale,
    input  quat_t rot,
    input  vec3_t trans,

    // output side
    output logic  out_valid,
    input  logic  out_ready,
    output vec3_t out_point
);

    logic  advance;                             // whole pipe moves together
    logic  scaled_valid;
    vec3_t scaled;
    quat_t rot_d;                               // rot lined up with scaled
    logic  rotated_valid;
    vec3_t rotated;
    vec3_t trans_d;                             // trans lined up with rotated

    // move unless a finished item is stuck at the output
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;                  // no skid, bubbles kept

    // scale stage
    vec_lane_op #(
        .OP (LANE_MUL)
    ) scale_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (advance),
        .valid_in  (in_valid),                  // only taken when in_ready
        .a         (point),
        .b         (scale),
        .valid_out (scaled_valid),
        .y         (scaled)
    );

    pipe_delay #(
        .payload_t (quat_t),
        .DEPTH     (LANE_LAT)
    ) rot_dly_i (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (advance),
        .d     (rot),
        .q     (rot_d)
    );

    vec_rotate rotate_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (advance),
        .valid_in  (scaled_valid),
        .v         (scaled),
        .rot       (rot_d),
        .valid_out (rotated_valid),
        .v_rot     (rotated)
    );

    // translation skips scale and rotate
    pipe_delay #(
        .payload_t (vec3_t),
        .DEPTH     (LANE_LAT + ROT_LAT)
    ) trans_dly_i (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (advance),
        .d     (trans),
        .q     (trans_d)
    );

    // last stage registers drive the outputs directly
    vec_lane_op #(
        .OP (LANE_ADD)
    ) translate_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (advance),
        .valid_in  (rotated_valid),
        .a         (rotated),
        .b         (trans_d),
        .valid_out (out_valid),
        .y         (out_point)               // held while stalled
    );

endmodule

/* quat/quat_mult.sv */
`timescale 1ns/100ps

// c = a * b, hamilton product in two stages
module quat_mult import xform_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,                           // global advance
    input  logic  valid_in,
    input  quat_t a,
    input  quat_t b,
    output logic  valid_out,
    output quat_t c
);

    prod_t prod_q [4][4];                       // [component][term]
    prod_t sum    [4];                          // signed hamilton sums
    logic  prod_valid;                          // stage one valid

    // stage one, all sixteen products
    // component r pairs a[t] with b[r ^ t]:
    //   real: b0 b1 b2 b3
    //   i:    b1 b0 b3 b2
    //   j:    b2 b3 b0 b1
    //   k:    b3 b2 b1 b0
    always_ff @(posedge clk) begin
        if (en) begin
            for (int r = 0; r < 4; r++) begin
                for (int t = 0; t < 4; t++) begin
                    prod_q[r][t] <= fix_prod(a[t], b[r ^ t]);   // kept full width
                end
            end
        end
    end

    // signs per QMUL_NEG
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            sum[r] = '0;
            for (int t = 0; t < 4; t++) begin
                if (QMUL_NEG[r][t]) begin
                    sum[r] = sum[r] - prod_q[r][t];
                end else begin
                    sum[r] = sum[r] + prod_q[r][t];
                end
            end
        end
    end

    // stage two, one shift per component after the sum
    always_ff @(posedge clk) begin
        if (en) begin
            for (int r = 0; r < 4; r++) begin
                c[r] <= fix_trunc(sum[r]);      // wrap above bit 31 does not reach [23:8]
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            valid_out  <= 1'b0;
        end else if (en) begin
            prod_valid <= valid_in;
            valid_out  <= prod_valid;
        end
    end

endmodule

/* quat/vec_rotate.sv */
`timescale 1ns/100ps

// v_rot = rot * v * conj(rot)
module vec_rotate import xform_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,                           // global advance
    input  logic  valid_in,
    input  vec3_t v,
    input  quat_t rot,                          // assumed unit length
    output logic  valid_out,
    output vec3_t v_rot
);

    quat_t v_quat;                              // v as pure quaternion
    quat_t rot_conj;                            // conjugate at input time
    quat_t rot_conj_d;                          // conjugate aligned with rot_v
    quat_t rot_v;                               // first product
    logic  rot_v_valid;
    quat_t res;                                 // full sandwich result

    assign v_quat = {v[2], v[1], v[0], fix16_t'(0)};   // real part zero

    // negate vector part, two's complement
    assign rot_conj = {fix16_t'(-rot[3]), fix16_t'(-rot[2]), fix16_t'(-rot[1]), rot[0]};

    // first product, rot on the left
    quat_mult mult_rot_v_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .valid_in  (valid_in),
        .a         (rot),
        .b         (v_quat),
        .valid_out (rot_v_valid),
        .c         (rot_v)
    );

    // conjugate waits out the first product
    pipe_delay #(
        .payload_t (quat_t),
        .DEPTH     (QMUL_LAT)
    ) conj_dly_i (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .d     (rot_conj),
        .q     (rot_conj_d)
    );

    // second product, conjugate on the right
    quat_mult mult_conj_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .valid_in  (rot_v_valid),
        .a         (rot_v),
        .b         (rot_conj_d),
        .valid_out (valid_out),
        .c         (res)
    );

    // real part of res is zero up to truncation, dropped
    assign v_rot = {res[3], res[2], res[1]};

endmodule

/* sim.f */
+incdir+testbench
common/xform_pkg.sv
hdl/pipe_delay.sv
hdl/vec_lane_op.sv
quat/quat_mult.sv
quat/vec_rotate.sv
hdl/xform_top.sv
testbench/xform_asserts.sv
testbench/xform_tb.sv

/* testbench/xform_asserts.sv */
`timescale 1ns/100ps

module xform_asserts import xform_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  in_ready,
    input logic  out_valid,
    input logic  out_ready,
    input vec3_t out_point
);

    int unsigned fail_count = 0;                // failures seen, read from the tb

    // async reset must hold out_valid low
    reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high while rst_n is low");
            fail_count++;
        end

    // stalled output stays put
    stall_holds_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_point))
        else begin
            $error("output changed while stalled");
            fail_count++;
        end

    // in_ready is the global advance
    ready_is_advance: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == !(out_valid && !out_ready))
        else begin
            $error("in_ready does not follow the stall condition");
            fail_count++;
        end

endmodule

/* testbench/xform_ref.svh */
`ifndef XFORM_REF_SVH
`define XFORM_REF_SVH

// q8.8 multiply, floor shift, low 16 bits kept
function automatic fix16_t q88_mul(input fix16_t a, input fix16_t b);
    longint p;
    p = longint'(a) * longint'(b);              // exact, no overflow at 64 bits
    return fix16_t'(p >>> FRAC_BITS);
endfunction

// hamilton product, each component summed at full width then shifted once
function automatic quat_t quat_product(input quat_t a, input quat_t b);
    longint aw [4];
    longint bw [4];
    longint s  [4];
    quat_t  c;
    for (int n = 0; n < 4; n++) begin
        aw[n] = longint'(a[n]);                 // sign extended
        bw[n] = longint'(b[n]);
    end
    s[0] = aw[0] * bw[0] - aw[1] * bw[1] - aw[2] * bw[2] - aw[3] * bw[3];
    s[1] = aw[0] * bw[1] + aw[1] * bw[0] + aw[2] * bw[3] - aw[3] * bw[2];
    s[2] = aw[0] * bw[2] - aw[1] * bw[3] + aw[2] * bw[0] + aw[3] * bw[1];
    s[3] = aw[0] * bw[3] + aw[1] * bw[2] - aw[2] * bw[1] + aw[3] * bw[0];
    for (int n = 0; n < 4; n++) begin
        c[n] = fix16_t'(s[n] >>> FRAC_BITS);    // bits 23:8 of the sum
    end
    return c;
endfunction

// conjugate, vector part negated with 16-bit wrap
function automatic quat_t quat_conj(input quat_t q);
    quat_t c;
    c[0] = q[0];
    for (int n = 1; n < 4; n++) begin
        c[n] = -q[n];
    end
    return c;
endfunction

// q * v * conj(q), v as pure quaternion
function automatic vec3_t rotate_vec(input vec3_t v, input quat_t q);
    quat_t vq;
    quat_t r;
    vec3_t o;
    vq[0] = '0;
    for (int n = 0; n < 3; n++) begin
        vq[n+1] = v[n];
    end
    r = quat_product(quat_product(q, vq), quat_conj(q));
    for (int n = 0; n < 3; n++) begin
        o[n] = r[n+1];                          // real part dropped
    end
    return o;
endfunction

// scale, rotate, translate
function automatic vec3_t xform_ref(input vec3_t point, input vec3_t scale,
                                    input quat_t rot, input vec3_t trans);
    vec3_t s;
    vec3_t r;
    vec3_t y;
    for (int n = 0; n < 3; n++) begin
        s[n] = q88_mul(point[n], scale[n]);
    end
    r = rotate_vec(s, rot);
    for (int n = 0; n < 3; n++) begin
        y[n] = r[n] + trans[n];                 // wraps like the hardware
    end
    return y;
endfunction

`endif

/* testbench/xform_tb.sv */
`timescale 1ns/100ps

module xform_tb import xform_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int SAMPLE_DLY  = CLK_PERIOD / 4;    // mid low phase, inputs settled
    localparam int RST_CYCLES  = 8;
    localparam int SEED        = 1836;
    localparam int N_IDENT     = 8;
    localparam int N_SCALE     = 32;
    localparam int N_ROT       = 6;
    localparam int N_STREAM    = 200;
    localparam int N_ITEMS     = 1 + N_IDENT + N_SCALE + N_ROT + N_STREAM;
    localparam int WDOG_CYCLES = N_ITEMS * (XFORM_LAT + 4) + 200;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    logic  in_ready;
    vec3_t point;
    vec3_t scale;
    quat_t rot;
    vec3_t trans;
    logic  out_valid;
    logic  out_ready;
    vec3_t out_point;

    vec3_t exp_q [$];                           // expected results in order
    vec3_t cur_exp;                             // expected value of the item on the bus
    int    errors;
    int    test_errs;                           // error count at test start
    int    test_items;
    int    tests_run;
    int    tests_failed;
    logic  bp_on;                               // random out_ready when set

    `include "xform_ref.svh"

    xform_top xform_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .point     (point),
        .scale     (scale),
        .rot       (rot),
        .trans     (trans),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_point (out_point)
    );

    bind xform_top xform_asserts xform_asserts_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic vec3_t rand_vec();
        vec3_t v;
        for (int n = 0; n < 3; n++) begin
            v[n] = fix16_t'($urandom);
        end
        return v;
    endfunction

    function automatic quat_t rand_quat();
        quat_t q;
        for (int n = 0; n < 4; n++) begin
            q[n] = fix16_t'($urandom);
        end
        return q;
    endfunction

    function automatic string vec_str(input vec3_t v);
        return $sformatf("(%0d,%0d,%0d)", v[0], v[1], v[2]);
    endfunction

    // present one item and hold it until taken
    task automatic send_item(input vec3_t p, input vec3_t s, input quat_t r,
                             input vec3_t t, input vec3_t e);
        bit taken;
        @(negedge clk);
        point    = p;
        scale    = s;
        rot      = r;
        trans    = t;
        cur_exp  = e;
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            #(SAMPLE_DLY);
            taken = in_ready;                   // transfer at the coming edge
            if (!taken) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic begin_test();
        test_errs  = errors;
        test_items = 0;
    endtask

    // drain, look for strays, report one line
    task automatic end_test(input string name);
        int waited;
        int errs;
        go_idle();
        @(posedge clk);
        bp_on  = 1'b0;                          // ready goes high at next falling edge
        waited = 0;
        while (exp_q.size() > 0 && waited < 4 * XFORM_LAT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("error at %0t: %0d results never came out", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (XFORM_LAT + 2) @(negedge clk);  // extra outputs hit an empty queue
        errs = errors - test_errs;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d items, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "FAILED", test_items, errs);
    endtask

    // scoreboard, both sides sampled in the stable window
    initial begin : monitor
        vec3_t exp_v;
        forever begin
            @(negedge clk);
            #(SAMPLE_DLY);
            if (rst_n && in_valid && in_ready) begin
                exp_q.push_back(cur_exp);
                test_items++;
            end
            if (rst_n && out_valid && out_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("error at %0t: output transfer with nothing outstanding", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_v = exp_q.pop_front();
                    assert (out_point == exp_v) else begin
                        $display("ERR t=%0t out_point exp=%s got=%s", $time,
                                 vec_str(exp_v), vec_str(out_point));
                        errors++;
                    end
                end
            end
        end
    end

    initial begin : ready_gen
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            out_ready = bp_on ? ($urandom_range(3) != 0) : 1'b1;   // 3 of 4 ready
        end
    end

    initial begin : watchdog
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: run not done after %0d cycles, %0d results outstanding",
                 WDOG_CYCLES, exp_q.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        vec3_t id_scale;
        quat_t id_rot;
        quat_t rot_z;
        vec3_t p;
        vec3_t s;
        vec3_t t;
        quat_t r;
        int    lat;
        int    total;
        void'($urandom(SEED));
        rst_n        = 1'b1;
        in_valid     = 1'b0;
        point        = '0;
        scale        = '0;
        rot          = '0;
        trans        = '0;
        cur_exp      = '0;
        bp_on        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int n = 0; n < 3; n++) begin
            id_scale[n] = 16'sd256;             // 1.0
        end
        id_rot    = '0;
        id_rot[0] = 16'sd256;
        rot_z     = '0;
        rot_z[0]  = 16'sd181;                   // cos 45, 90 deg about z
        rot_z[3]  = 16'sd181;
        #1 rst_n = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // 1: reset state, then one item for latency
        begin_test();
        assert (out_valid === 1'b0) else begin
            $display("error at %0t: out_valid not low after reset", $time);
            errors++;
        end
        p = rand_vec();
        send_item(p, id_scale, id_rot, '0, xform_ref(p, id_scale, id_rot, '0));
        @(negedge clk);
        in_valid = 1'b0;
        #(SAMPLE_DLY);
        lat = 1;
        while (!out_valid && lat < 4 * XFORM_LAT) begin
            @(negedge clk);
            #(SAMPLE_DLY);
            lat++;
        end
        assert (lat == XFORM_LAT) else begin
            $display("error at %0t: out_valid came %0d cycles after acceptance, not %0d",
                     $time, lat, XFORM_LAT);
            errors++;
        end
        end_test("reset and latency");

        // 2: identity, result is the point itself
        begin_test();
        for (int i = 0; i < N_IDENT; i++) begin
            p = rand_vec();
            send_item(p, id_scale, id_rot, '0, p);
        end
        end_test("identity");

        // 3: scale and translate only
        begin_test();
        for (int i = 0; i < N_SCALE; i++) begin
            p = rand_vec();
            s = rand_vec();
            t = rand_vec();
            send_item(p, s, id_rot, t, xform_ref(p, s, id_rot, t));
        end
        end_test("scale and translate");

        // 4: axis points turned about z
        begin_test();
        for (int i = 0; i < N_ROT; i++) begin
            p          = '0;
            p[i % 3]   = (i < 3) ? 16'sd256 : -16'sd512;
            send_item(p, id_scale, rot_z, '0, xform_ref(p, id_scale, rot_z, '0));
        end
        end_test("rotate about z");

        // 5: random stream, gaps on input, stalls on output
        begin_test();
        @(posedge clk);
        bp_on = 1'b1;
        for (int i = 0; i < N_STREAM; i++) begin
            if ($urandom_range(1) == 0) begin
                go_idle();                      // bubble
            end
            p = rand_vec();
            s = rand_vec();
            t = rand_vec();
            r = rand_quat();
            send_item(p, s, r, t, xform_ref(p, s, r, t));
        end
        end_test("random stream with back-pressure");

        total = errors + xform_top_i.xform_asserts_i.fail_count;
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, xform_top_i.xform_asserts_i.fail_count);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
